// ==== sim.f ====
hdl/backend_pkg.sv
hdl/mem_access.sv
hdl/data_ram.sv
hdl/memory_main.sv
hdl/writeback.sv
hdl/backend_top.sv
test/backend_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the back end testbench with Verilator
# exits non zero when the log holds the fail message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module backend_tb -o backend_sim -f sim.f \
        || { echo "build failed"; exit 1; }

./obj_dir/backend_sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "simulation reported errors"; exit 1; } || exit 0

// ==== test/backend_tb.sv ====
// back end testbench
// directed tests for ALU writes, loads and stores, flags, exceptions
// and stalls, checked against a model of registers, flags and RAM
`timescale 1ns/10ps
`default_nettype none

module backend_tb;

import backend_pkg::*;

localparam int RAM_WORDS  = 256;
localparam int CLK_PERIOD = 40;
localparam int NUM_TESTS  = 5;

logic              i_clk;
logic              i_reset;
logic              i_stall;
alu_out_t          alu_in;                      // instruction from the modelled ALU
reg_idx_t          i_rd_index;
logic [DATA_W-1:0] o_rd_data;
logic [DATA_W-1:0] o_exc_pc;
flags_t            o_flags;
logic              o_retire;
logic              o_exception;
exc_code_t         o_exc_code;

logic [DATA_W-1:0] reg_model [16];
logic [DATA_W-1:0] ram_model [RAM_WORDS];
flags_t            flag_model;
exc_code_t         exc_codes [$];               // exceptions seen by the monitor
logic [DATA_W-1:0] exc_pcs [$];
int                retire_cnt;
int                err_cnt;
int                check_cnt;
int                tests_run;
int                errs_at_start;               // error count when the test began
logic [DATA_W-1:0] pc_next;

backend_top #(.RAM_WORDS(RAM_WORDS)) backend_top_inst (
        .i_clk(i_clk), .i_reset(i_reset), .i_stall(i_stall), .i_alu_out(alu_in),
        .i_rd_index(i_rd_index), .o_rd_data(o_rd_data), .o_flags(o_flags),
        .o_retire(o_retire), .o_exception(o_exception), .o_exc_code(o_exc_code),
        .o_exc_pc(o_exc_pc)
);

initial
begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
end

// watchdog, every test fits in 200 cycles
initial
begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", NUM_TESTS * 200);
        $display("RESULT: FAIL");
        $finish;
end

// status pulses sampled mid cycle
always @(negedge i_clk)
begin
        if (!i_reset && o_retire)
                retire_cnt++;
        if (!i_reset && o_exception)
        begin
                exc_codes.push_back(o_exc_code);
                exc_pcs.push_back(o_exc_pc);
        end
end

task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                          input logic [DATA_W-1:0] exp);
        check_cnt++;
        if (got !== exp)
        begin
                $display("error: %s got %h expected %h", name, got, exp);
                err_cnt++;
        end
endtask

task automatic check_flags(input flags_t got, input flags_t exp);
        check_cnt++;
        if (got !== exp)
        begin
                $display("error: o_flags got %h expected %h", got, exp);
                err_cnt++;
        end
endtask

task automatic check_exc(input exc_code_t got, input exc_code_t exp);
        check_cnt++;
        if (got !== exp)
        begin
                $display("error: o_exc_code got %h expected %h", got, exp);
                err_cnt++;
        end
endtask

// abort outranks fiq, fiq outranks irq, irq outranks swi
function automatic exc_code_t expected_code(input exc_t e);
        casez ({e.instr_abort, e.fiq, e.irq, e.swi})
                4'b1???: return EXC_ABORT;
                4'b01??: return EXC_FIQ;
                4'b001?: return EXC_IRQ;
                4'b0001: return EXC_SWI;
                default: return EXC_NONE;
        endcase
endfunction

function automatic alu_out_t alu_write(input reg_idx_t d, input logic [DATA_W-1:0] v);
        alu_out_t ins;
        ins            = '0;
        ins.dav        = 1'b1;
        ins.pc_plus_8  = pc_next + 32'd8;
        ins.dest_index = d;
        ins.dest_write = 1'b1;
        ins.alu_result = v;
        pc_next        = pc_next + 32'd4;
        return ins;
endfunction

// commit rules applied in program order
task automatic apply_model(input alu_out_t ins);
        int unsigned a = (ins.alu_result >> 2) % RAM_WORDS;   // word address
        if (ins.dav && ins.exc == '0)
        begin
                for (int b = 0; b < 4; b++)
                        if (ins.mem_store && ins.mem_byte_en[b])
                                ram_model[a][8*b +: 8] = ins.store_data[8*b +: 8];
                if (ins.dest_write)
                        reg_model[ins.dest_index] = ins.alu_result;
                if (ins.mem_load)
                        reg_model[ins.mem_srcdest_index] = ram_model[a];  // load wins
                if (ins.flag_update)
                        flag_model = ins.flags;
        end
endtask

// drive for one edge, caller sits 2 ns after a rising edge
task automatic issue(input alu_out_t ins, input logic commits);
        alu_in = ins;
        if (commits)
                apply_model(ins);
        @(posedge i_clk);
        #2;
endtask

task automatic idle(input int n);
        repeat (n) issue('0, 1'b0);
endtask

task automatic read_all_regs();
        for (int r = 0; r < 16; r++)
        begin
                i_rd_index = reg_idx_t'(r);
                #1;                             // async read port settles
                check_word($sformatf("o_rd_data r%0d", r), o_rd_data, reg_model[r]);
        end
endtask

task automatic report_test(input string name);
        tests_run++;
        if (err_cnt == errs_at_start)
                $display("test %s: ok", name);
        else
                $display("test %s: %0d errors", name, err_cnt - errs_at_start);
        errs_at_start = err_cnt;
endtask

task automatic write_random_regs();
        int ret_before = retire_cnt;
        for (int i = 0; i < 16; i++)
                issue(alu_write(4'($urandom), $urandom), 1'b1);
        idle(3);
        check_word("retire count", 32'(retire_cnt - ret_before), 32'd16);
        check_word("exception count", 32'(exc_codes.size()), 32'd0);
        read_all_regs();
endtask

task automatic store_then_load();
        alu_out_t st;
        alu_out_t ld;
        for (int i = 0; i < 8; i++)
        begin
                st             = alu_write(4'd0, ($urandom % RAM_WORDS) << 2);
                st.dest_write  = 1'b0;
                st.mem_store   = 1'b1;
                st.mem_byte_en = 4'hf;          // full word, known contents
                st.store_data  = $urandom;
                issue(st, 1'b1);
                st.mem_byte_en = 4'($urandom);  // partial merge on top
                st.store_data  = $urandom;
                issue(st, 1'b1);
                ld                   = alu_write(4'd0, st.alu_result);
                ld.mem_load          = 1'b1;
                ld.mem_srcdest_index = 4'($urandom);
                ld.dest_index        = ld.mem_srcdest_index ^ 4'(i % 2); // even: same reg
                issue(ld, 1'b1);
                idle(3);
                read_all_regs();
        end
        check_word("exception count", 32'(exc_codes.size()), 32'd0);
endtask

task automatic update_flags();
        alu_out_t ins;
        int       ret_before = retire_cnt;
        for (int i = 0; i < 12; i++)
        begin
                ins             = alu_write(4'd0, 32'd0);
                ins.dest_write  = 1'b0;
                ins.flags       = 4'($urandom);
                ins.flag_update = 1'($urandom);
                issue(ins, 1'b1);
                idle(3);
                check_flags(o_flags, flag_model);
        end
        check_word("retire count", 32'(retire_cnt - ret_before), 32'd12);
        check_word("exception count", 32'(exc_codes.size()), 32'd0);
endtask

// every nonzero exception pattern, then two victims and one survivor
task automatic rank_exceptions();
        alu_out_t e;
        int       ret_before;
        for (int p = 1; p < 16; p++)
        begin
                exc_codes.delete();
                exc_pcs.delete();
                ret_before    = retire_cnt;
                e             = alu_write(4'd1, $urandom);
                e.flag_update = 1'b1;
                e.flags       = 4'($urandom);
                e.exc         = 4'(p);
                issue(e, 1'b1);                 // model drops it by itself
                issue(alu_write(4'd2, $urandom), 1'b0);
                issue(alu_write(4'd3, $urandom), 1'b0);
                issue(alu_write(4'd4, 32'(p)), 1'b1);
                idle(3);
                if (exc_codes.size() != 1)
                begin
                        $display("error: pattern %b gave %0d exceptions instead of one",
                                 e.exc, exc_codes.size());
                        err_cnt++;
                end
                else
                begin
                        check_exc(exc_codes[0], expected_code(e.exc));
                        check_word("o_exc_pc", exc_pcs[0], e.pc_plus_8 - 32'd4);
                end
                check_word("retire count", 32'(retire_cnt - ret_before), 32'd1);
                read_all_regs();
                check_flags(o_flags, flag_model);
        end
        exc_codes.delete();
        exc_pcs.delete();
endtask

// r7 watched through the read port, one new value per retire
task automatic retire_under_stall();
        alu_out_t          prog [12];
        logic [DATA_W-1:0] vals [12];
        int                idx = 0;
        int                got = 0;
        int                ret_before = retire_cnt;
        for (int i = 0; i < 12; i++)
        begin
                vals[i]             = $urandom;
                prog[i]             = alu_write(4'd7, vals[i]);
                prog[i].flag_update = 1'b1;
                prog[i].flags       = 4'($urandom);
        end
        i_rd_index = 4'd7;
        while (got < 12)
        begin
                i_stall = (($urandom % 3) == 0);
                alu_in  = (idx < 12) ? prog[idx] : '0;
                if (!i_stall && idx < 12)
                begin
                        apply_model(prog[idx]); // taken at this edge
                        idx++;
                end
                @(negedge i_clk);
                if (o_retire)
                begin
                        check_word("o_rd_data r7", o_rd_data, vals[got]);
                        got++;
                end
                @(posedge i_clk);
                #2;
        end
        i_stall = 1'b0;
        idle(3);
        check_word("retire count", 32'(retire_cnt - ret_before), 32'd12);
        check_word("exception count", 32'(exc_codes.size()), 32'd0);
        check_flags(o_flags, flag_model);
        read_all_regs();
endtask

initial
begin
        i_reset    = 1'b1;
        i_stall    = 1'b0;
        alu_in     = '0;
        i_rd_index = '0;
        pc_next    = 32'h100;
        flag_model = '0;
        void'($urandom(98919));
        for (int r = 0; r < 16; r++)
                reg_model[r] = '0;
        repeat (5) @(posedge i_clk);
        #2;
        i_reset = 1'b0;
        read_all_regs();                        // registers and flags cleared
        check_flags(o_flags, '0);
        report_test("reset");
        write_random_regs();
        report_test("alu writes");
        store_then_load();
        report_test("store and load");
        update_flags();
        report_test("flags");
        rank_exceptions();
        report_test("exceptions");
        retire_under_stall();
        report_test("stall");
        $display("tests %0d, checks %0d, errors %0d", tests_run, check_cnt, err_cnt);
        if (err_cnt == 0)
                $display("RESULT: PASS");
        else
                $display("RESULT: FAIL");
        $finish;
end

endmodule

`default_nettype wire

// ==== hdl/backend_top.sv ====
// processor back end top
// mem access, data RAM, buffer stage and writeback wired in a row
`timescale 1ns/10ps
`default_nettype none

module backend_top #(
        parameter int RAM_WORDS = 256
) (
        input  wire                                 i_clk,
        input  wire                                 i_reset,
        input  wire                                 i_stall,
        input  wire backend_pkg::alu_out_t          i_alu_out,
        input  wire backend_pkg::reg_idx_t          i_rd_index,
        output logic [backend_pkg::DATA_W-1:0]      o_rd_data,
        output backend_pkg::flags_t                 o_flags,
        output logic                                o_retire,
        output logic                                o_exception,
        output backend_pkg::exc_code_t              o_exc_code,
        output logic [backend_pkg::DATA_W-1:0]      o_exc_pc
);

import backend_pkg::*;

mem_stage_t                   ma_mem;           // mem access -> buffer
mem_stage_t                   mm_mem;           // buffer -> writeback
logic                         clear;            // flush from writeback
logic [$clog2(RAM_WORDS)-1:0] ram_addr;
logic                         ram_we;
logic [3:0]                   ram_be;
logic [DATA_W-1:0]            ram_wdata;
logic [DATA_W-1:0]            ram_rdata;

mem_access #(.RAM_WORDS(RAM_WORDS)) mem_access_inst (
        .i_clk(i_clk), .i_reset(i_reset), .i_stall(i_stall), .i_clear(clear),
        .i_alu_out(i_alu_out), .o_ram_addr(ram_addr), .o_ram_we(ram_we),
        .o_ram_be(ram_be), .o_ram_wdata(ram_wdata), .o_mem(ma_mem)
);

data_ram #(.RAM_WORDS(RAM_WORDS)) data_ram_inst (
        .i_clk(i_clk), .i_addr(ram_addr), .i_we(ram_we), .i_be(ram_be),
        .i_wdata(ram_wdata), .i_re(~i_stall), .o_rdata(ram_rdata)
);

memory_main memory_main_inst (
        .i_clk(i_clk), .i_reset(i_reset), .i_clear(clear), .i_stall(i_stall),
        .i_mem(ma_mem), .i_mem_rd_data(ram_rdata), .o_mem(mm_mem)
);

writeback writeback_inst (
        .i_clk(i_clk), .i_reset(i_reset), .i_stall(i_stall), .i_mem(mm_mem),
        .i_rd_index(i_rd_index), .o_clear(clear), .o_rd_data(o_rd_data),
        .o_flags(o_flags), .o_retire(o_retire), .o_exception(o_exception),
        .o_exc_code(o_exc_code), .o_exc_pc(o_exc_pc)
);

endmodule

`default_nettype wire

// ==== hdl/writeback.sv ====
// writeback stage
// holds the register file and the flags, ranks exceptions,
// commits results and raises the flush for the younger stages
`timescale 1ns/10ps
`default_nettype none

module writeback (
        input  wire                                 i_clk,
        input  wire                                 i_reset,
        input  wire                                 i_stall,
        input  wire backend_pkg::mem_stage_t        i_mem,          // buffered instruction
        input  wire backend_pkg::reg_idx_t          i_rd_index,     // decode read port
        output logic                                o_clear,        // flush, combinational
        output logic [backend_pkg::DATA_W-1:0]      o_rd_data,
        output backend_pkg::flags_t                 o_flags,
        output logic                                o_retire,
        output logic                                o_exception,
        output backend_pkg::exc_code_t              o_exc_code,
        output logic [backend_pkg::DATA_W-1:0]      o_exc_pc
);

import backend_pkg::*;

localparam int NUM_REGS = 2 ** $bits(reg_idx_t);

logic [DATA_W-1:0] regs [NUM_REGS];     // register file
exc_code_t         exc_code;            // ranked exception of i_mem
logic              excepting;           // valid instruction with an exception
logic              commit;              // valid instruction, clean

// fixed priority: abort, fiq, irq, swi
always_comb
begin
        if (i_mem.exc.instr_abort)
                exc_code = EXC_ABORT;
        else if (i_mem.exc.fiq)
                exc_code = EXC_FIQ;
        else if (i_mem.exc.irq)
                exc_code = EXC_IRQ;
        else if (i_mem.exc.swi)
                exc_code = EXC_SWI;
        else
                exc_code = EXC_NONE;
end

assign excepting = i_mem.dav & (exc_code != EXC_NONE) & ~i_stall;
assign commit    = i_mem.dav & (exc_code == EXC_NONE) & ~i_stall;
assign o_clear   = excepting;           // empties both younger stages at the edge

assign o_rd_data = regs[i_rd_index];    // async read for decode

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                for (int i = 0; i < NUM_REGS; i++)
                begin
                        regs[i] <= '0;
                end
        end
        else if (commit)
        begin
                if (i_mem.dest_write)
                        regs[i_mem.dest_index] <= i_mem.alu_result;
                // later assignment, so the load wins on the same index
                if (i_mem.mem_load)
                        regs[i_mem.mem_srcdest_index] <= i_mem.mem_rd_data;
        end
end

// flags and one cycle status pulses, aligned with the commit edge
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_flags     <= '0;
                o_retire    <= 1'b0;
                o_exception <= 1'b0;
                o_exc_code  <= EXC_NONE;
        end
        else
        begin
                if (commit && i_mem.flag_update)
                        o_flags <= i_mem.flags;
                o_retire    <= commit;          // zero under stall, so no repeat
                o_exception <= excepting;
                o_exc_code  <= excepting ? exc_code : EXC_NONE;
        end
end

// return address of the excepting instruction
always_ff @(posedge i_clk)
begin
        if (excepting)
                o_exc_pc <= i_mem.pc_plus_8 - DATA_W'(4);
end

assert property (@(posedge i_clk) disable iff (i_reset) !(o_retire && o_exception))
        else $error("writeback: retire and exception together");

// flush reaches the buffer stage at the very next edge
assert property (@(posedge i_clk) disable iff (i_reset) o_clear |=> !i_mem.dav)
        else $error("writeback: instruction survived a clear");

endmodule

`default_nettype wire

// ==== hdl/memory_main.sv ====
// memory main buffer stage
// sits between mem access and writeback so the data RAM gets a
// full clock, captures the instruction together with the RAM word
`timescale 1ns/10ps
`default_nettype none

module memory_main (
        input  wire                                 i_clk,
        input  wire                                 i_reset,
        input  wire                                 i_clear,        // flush from writeback
        input  wire                                 i_stall,        // global freeze
        input  wire backend_pkg::mem_stage_t        i_mem,          // from mem access
        input  wire [backend_pkg::DATA_W-1:0]       i_mem_rd_data,  // ram word, one edge late
        output backend_pkg::mem_stage_t             o_mem           // to writeback
);

import backend_pkg::*;

mem_stage_t mem_nxt;

// merge the ram word into the struct
always_comb
begin
        mem_nxt             = i_mem;
        mem_nxt.mem_rd_data = i_mem_rd_data;    // only meaningful for loads
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_mem <= '0;
        end
        else if (i_clear)
        begin
                o_mem <= '0;                    // kill the younger instruction
        end
        else if (i_stall)
        begin
                o_mem <= o_mem;                 // hold everything
        end
        else
        begin
                o_mem <= mem_nxt;
        end
end

// a bubble from mem access stays a bubble while frozen
assert property (@(posedge i_clk) disable iff (i_reset)
        (i_stall && !i_mem.dav) |=> !i_mem.dav)
        else $error("memory_main: valid rose during stall");

endmodule

`default_nettype wire

// ==== hdl/data_ram.sv ====
// data RAM
// single port word memory with byte lane writes,
// read word is registered and held while the read enable is low
`timescale 1ns/10ps
`default_nettype none

module data_ram #(
        parameter int RAM_WORDS = 256
) (
        input  wire                                 i_clk,
        input  wire [$clog2(RAM_WORDS)-1:0]         i_addr,     // word address
        input  wire                                 i_we,
        input  wire [3:0]                           i_be,       // byte lane enables
        input  wire [backend_pkg::DATA_W-1:0]       i_wdata,
        input  wire                                 i_re,       // low under stall
        output logic [backend_pkg::DATA_W-1:0]      o_rdata
);

import backend_pkg::*;

logic [DATA_W-1:0] mem [RAM_WORDS];                             // no reset on the array

// lane by lane write
always_ff @(posedge i_clk)
begin
        for (int b = 0; b < $bits(i_be); b++)
        begin
                if (i_we && i_be[b])
                begin
                        mem[i_addr][8*b +: 8] <= i_wdata[8*b +: 8];
                end
        end
end

// read before write on the same address
always_ff @(posedge i_clk)
begin
        if (i_re)
        begin
                o_rdata <= mem[i_addr];
        end
end

endmodule

`default_nettype wire

// ==== hdl/mem_access.sv ====
// memory access stage
// drives the data RAM port straight from the incoming instruction
// and registers the instruction, minus the store fields, for the buffer
`timescale 1ns/10ps
`default_nettype none

module mem_access #(
        parameter int RAM_WORDS = 256                           // ram depth in words
) (
        input  wire                                 i_clk,
        input  wire                                 i_reset,
        input  wire                                 i_stall,    // freezes the stage
        input  wire                                 i_clear,    // flush from writeback
        input  wire backend_pkg::alu_out_t          i_alu_out,
        output logic [$clog2(RAM_WORDS)-1:0]        o_ram_addr,
        output logic                                o_ram_we,
        output logic [3:0]                          o_ram_be,
        output logic [backend_pkg::DATA_W-1:0]      o_ram_wdata,
        output backend_pkg::mem_stage_t             o_mem
);

import backend_pkg::*;

localparam int ADDR_W = $clog2(RAM_WORDS);

mem_stage_t mem_nxt;                                            // next value of o_mem

// byte address to word address, upper bits beyond the ram dropped
assign o_ram_addr  = i_alu_out.alu_result[ADDR_W+1:2];
assign o_ram_we    = i_alu_out.dav & i_alu_out.mem_store & ~i_stall; // no write while frozen
assign o_ram_be    = i_alu_out.mem_byte_en;
assign o_ram_wdata = i_alu_out.store_data;

always_comb
begin
        mem_nxt                   = '0;
        mem_nxt.dav               = i_alu_out.dav;
        mem_nxt.alu_result        = i_alu_out.alu_result;
        mem_nxt.flags             = i_alu_out.flags;
        mem_nxt.flag_update       = i_alu_out.flag_update;
        mem_nxt.dest_index        = i_alu_out.dest_index;
        mem_nxt.dest_write        = i_alu_out.dest_write;
        mem_nxt.mem_load          = i_alu_out.mem_load;
        mem_nxt.mem_store         = i_alu_out.mem_store;
        mem_nxt.mem_srcdest_index = i_alu_out.mem_srcdest_index;
        mem_nxt.pc_plus_8         = i_alu_out.pc_plus_8;
        mem_nxt.exc               = i_alu_out.exc;
        // mem_rd_data stays zero, ram word arrives a cycle later
end

always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
        begin
                o_mem <= '0;                                    // empty the stage
        end
        else if (!i_stall)
        begin
                o_mem <= mem_nxt;
        end
end

// the ALU stage never issues a load that is also a store
assert property (@(posedge i_clk) disable iff (i_reset)
        i_alu_out.dav |-> !(i_alu_out.mem_load && i_alu_out.mem_store))
        else $error("mem_access: load and store in one instruction");

endmodule

`default_nettype wire

// ==== hdl/backend_pkg.sv ====
// back end shared definitions
// data width, register index, flags, exception bits and the
// instruction structs that move between the back end stages
`default_nettype none

package backend_pkg;

localparam int DATA_W = 32;                     // one machine word

typedef logic [3:0] reg_idx_t;                  // 16 architectural registers

typedef struct packed {
        logic n;                                // negative
        logic z;                                // zero
        logic c;                                // carry
        logic v;                                // overflow
} flags_t;

// exception bits in the order the ALU stage hands them over
typedef struct packed {
        logic instr_abort;
        logic fiq;
        logic irq;
        logic swi;
} exc_t;

typedef enum logic [2:0] {
        EXC_NONE,
        EXC_ABORT,
        EXC_FIQ,
        EXC_IRQ,
        EXC_SWI
} exc_code_t;

// one instruction leaving the ALU stage
typedef struct packed {
        logic              dav;                 // valid
        logic [DATA_W-1:0] alu_result;          // also the load/store address
        flags_t            flags;
        logic              flag_update;
        reg_idx_t          dest_index;
        logic              dest_write;
        logic              mem_load;
        logic              mem_store;
        logic [3:0]        mem_byte_en;         // one bit per byte lane
        reg_idx_t          mem_srcdest_index;   // load target
        logic [DATA_W-1:0] store_data;
        logic [DATA_W-1:0] pc_plus_8;
        exc_t              exc;
} alu_out_t;

// instruction between mem access, buffer and writeback
typedef struct packed {
        logic              dav;
        logic [DATA_W-1:0] alu_result;
        flags_t            flags;
        logic              flag_update;
        reg_idx_t          dest_index;
        logic              dest_write;
        logic              mem_load;
        logic              mem_store;
        reg_idx_t          mem_srcdest_index;
        logic [DATA_W-1:0] pc_plus_8;
        exc_t              exc;
        logic [DATA_W-1:0] mem_rd_data;         // filled in by the buffer stage
} mem_stage_t;

endpackage

`default_nettype wire
